//--- verilog.f
+incdir+.
fetch_pkg.sv
pc_gen.sv
icache.sv
fetch_buffer.sv
fetch_top.sv
fetch_properties.sv
tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fetch testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f verilog.f --top-module tb_fetch -o tb_fetch_sim \
    && ./obj_dir/tb_fetch_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "fetch run passed" \
    || { echo "fetch run failed"; exit 1; }

//--- tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch import fetch_pkg::*; ();

    // about 120 deliveries plus up to ~10 cycles for each line miss
    localparam int WATCHDOG_CYCLES = 4000;

    localparam addr_t EPC_ADDR  = 32'hbfc01000;
    localparam addr_t BR_ADDR   = 32'hbfc02040;
    localparam addr_t LOOP_BASE = 32'hbfc03000;   // loop stays within the warmed lines

    logic      clk;
    logic      reset;
    logic      br_taken;
    addr_t     br_target;
    logic      br_delay_slot;
    logic      flush;
    logic      eret;
    addr_t     epc;
    logic      dec_valid;
    logic      dec_ready;
    addr_t     dec_pc;
    inst_t     dec_inst;
    logic      dec_bd;
    logic      dec_exc;
    exc_code_t dec_exc_code;
    logic      mem_req_valid;
    logic      mem_req_ready;
    addr_t     mem_req_addr;
    logic      mem_resp_valid;
    inst_t     mem_resp_data;

    // scoreboard state
    addr_t     exp_pc;           // next pc decode should see
    logic      exp_bd;
    logic      exp_exc;          // next delivery is an address error
    logic      quiet;            // parked after an address error
    logic      hit_loop;         // no refill allowed while set
    int        delivered;
    string     test_name;
    logic      failed;
    logic      verdict_printed;

    fetch_top u_fetch_top (
        .clk           (clk),
        .reset         (reset),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .br_delay_slot (br_delay_slot),
        .flush         (flush),
        .eret          (eret),
        .epc           (epc),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pc        (dec_pc),
        .dec_inst      (dec_inst),
        .dec_bd        (dec_bd),
        .dec_exc       (dec_exc),
        .dec_exc_code  (dec_exc_code),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data (mem_resp_data)
    );

    bind fetch_top fetch_properties u_fetch_properties (
        .clk          (clk),
        .reset        (reset),
        .br_taken     (br_taken),
        .flush        (flush),
        .eret         (eret),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_pc       (dec_pc),
        .dec_inst     (dec_inst),
        .dec_bd       (dec_bd),
        .dec_exc      (dec_exc),
        .dec_exc_code (dec_exc_code),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_addr (mem_req_addr),
        .hit_loop     (tb_fetch.hit_loop)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;       // 10 ns period

    task automatic flag_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        failed          = 1'b1;
        verdict_printed = 1'b1;
        $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("Simulation finished: FAIL");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic stop_on_failure(input string why);
        failed          = 1'b1;
        verdict_printed = 1'b1;
        $display("%s: %s", test_name, why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    // runs after the inputs settle and before the rising edge
    task automatic check_delivery();
        if (quiet) begin
            assert (!dec_valid)
                else stop_on_failure("instruction delivered after an address error, no redirect");
        end
        if (dec_valid && dec_ready) begin
            assert (dec_pc == exp_pc) else flag_mismatch("dec_pc", exp_pc, dec_pc);
            assert (dec_bd == exp_bd) else flag_mismatch("dec_bd", 32'(exp_bd), 32'(dec_bd));
            assert (dec_exc == exp_exc) else flag_mismatch("dec_exc", 32'(exp_exc), 32'(dec_exc));
            if (exp_exc) begin
                assert (dec_exc_code == `EXC_ADEL)
                    else flag_mismatch("dec_exc_code", 32'(`EXC_ADEL), 32'(dec_exc_code));
                assert (dec_inst == '0) else flag_mismatch("dec_inst", 32'd0, dec_inst);
                quiet = 1'b1;                           // fetch parks here
            end else begin
                assert (dec_exc_code == `EXC_NONE)
                    else flag_mismatch("dec_exc_code", 32'(`EXC_NONE), 32'(dec_exc_code));
                assert (dec_inst == ~exp_pc) else flag_mismatch("dec_inst", ~exp_pc, dec_inst);
            end
            exp_pc = exp_pc + 32'd4;
            exp_bd = 1'b0;                              // only the first is the slot
            delivered++;
        end
    endtask

    task automatic clock_step(input logic allow_ready);
        @(negedge clk);
        br_taken      = 1'b0;
        flush         = 1'b0;
        eret          = 1'b0;
        br_delay_slot = 1'b0;
        dec_ready     = allow_ready && ($urandom_range(3) != 0);   // ready ~3 of 4 cycles
        #1;
        check_delivery();
    endtask

    // one cycle redirect pulse with eret over flush over branch
    task automatic apply_redirect(input logic do_eret, input logic do_flush,
                                  input logic do_br, input logic bd, input addr_t target);
        @(negedge clk);
        eret          = do_eret;
        flush         = do_flush;
        br_taken      = do_br;
        br_delay_slot = bd;
        br_target     = target;
        dec_ready     = 1'b0;       // old stream retires nothing here
        if (do_eret) begin
            exp_pc = epc;
        end else if (do_flush) begin
            exp_pc = `FETCH_EXC_VECTOR;
        end else begin
            exp_pc = target;
        end
        exp_bd  = do_br && bd && !do_eret && !do_flush;
        exp_exc = (exp_pc[1:0] != 2'b00);
        quiet   = 1'b0;
    endtask

    task automatic take_instructions(input int count);
        int goal;
        goal = delivered + count;
        while (delivered < goal) begin
            clock_step(1'b1);
        end
    endtask

    // line refill responder
    initial begin : memory_model
        addr_t beat_addr;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        forever begin
            @(negedge clk);
            mem_resp_valid = 1'b0;
            if (!reset && mem_req_valid) begin
                repeat ($urandom_range(3)) @(negedge clk);    // 0 to 3 cycles late
                mem_req_ready = 1'b1;
                beat_addr     = mem_req_addr;
                assert (mem_req_addr[3:0] == 4'h0)            // whole lines only
                    else flag_mismatch("mem_req_addr offset", 32'd0, 32'(mem_req_addr[3:0]));
                @(negedge clk);
                mem_req_ready = 1'b0;
                for (int beat = 0; beat < `IC_LINE_WORDS; beat++) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = ~beat_addr;              // inverse of byte address
                    beat_addr      = beat_addr + 32'd4;
                    if (beat < `IC_LINE_WORDS - 1) begin
                        @(negedge clk);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'hd7e3_4372));
        reset           = 1'b1;
        br_taken        = 1'b0;
        br_target       = '0;
        br_delay_slot   = 1'b0;
        flush           = 1'b0;
        eret            = 1'b0;
        epc             = EPC_ADDR;
        dec_ready       = 1'b0;
        exp_pc          = `FETCH_RESET_PC;
        exp_bd          = 1'b0;
        exp_exc         = 1'b0;
        quiet           = 1'b0;
        hit_loop        = 1'b0;
        delivered       = 0;
        failed          = 1'b0;
        verdict_printed = 1'b0;
        test_name       = "reset";
        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_name = "sequential";
        take_instructions(24);
        test_name = "backpressure";
        repeat (12) clock_step(1'b0);                  // buffer fills and credits run dry
        take_instructions(16);

        test_name = "redirect_all";
        apply_redirect(1'b1, 1'b1, 1'b1, 1'b1, BR_ADDR);
        take_instructions(6);
        test_name = "flush_branch";
        apply_redirect(1'b0, 1'b1, 1'b1, 1'b1, BR_ADDR);
        take_instructions(6);
        test_name = "eret_branch";
        apply_redirect(1'b1, 1'b0, 1'b1, 1'b1, BR_ADDR);
        take_instructions(6);
        test_name = "eret_flush";
        apply_redirect(1'b1, 1'b1, 1'b0, 1'b0, BR_ADDR);
        take_instructions(6);
        test_name = "branch_slot";
        apply_redirect(1'b0, 1'b0, 1'b1, 1'b1, BR_ADDR + 32'h100);
        take_instructions(6);
        test_name = "branch_plain";
        apply_redirect(1'b0, 1'b0, 1'b1, 1'b0, BR_ADDR + 32'h208);   // miss on word 2
        take_instructions(6);

        test_name = "misaligned";
        apply_redirect(1'b0, 1'b0, 1'b1, 1'b0, BR_ADDR + 32'h2);
        take_instructions(1);
        repeat (20) clock_step(1'b1);                  // must stay silent

        test_name = "loop_warm";
        apply_redirect(1'b0, 1'b0, 1'b1, 1'b0, LOOP_BASE);
        take_instructions(12);
        test_name = "loop_hits";
        repeat (5) begin
            apply_redirect(1'b0, 1'b0, 1'b1, 1'b0, LOOP_BASE);
            take_instructions(1);
            hit_loop = 1'b1;                           // any leftover refill is done by now
            take_instructions(5);
        end
        hit_loop = 1'b0;

        verdict_printed = 1'b1;
        if (!failed) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        verdict_printed = 1'b1;
        $display("watchdog expired after %0d cycles, fetch stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    // run ended early without a verdict
    final begin
        if (!verdict_printed) begin
            $display("Simulation finished: FAIL");
        end
    end

endmodule

`default_nettype wire

//--- fetch_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_properties import fetch_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      br_taken,
    input logic      flush,
    input logic      eret,
    input logic      dec_valid,
    input logic      dec_ready,
    input addr_t     dec_pc,
    input inst_t     dec_inst,
    input logic      dec_bd,
    input logic      dec_exc,
    input exc_code_t dec_exc_code,
    input logic      mem_req_valid,
    input logic      mem_req_ready,
    input addr_t     mem_req_addr,
    input logic      hit_loop         // set while only cached lines are fetched
);

    // quiet outputs through reset and one cycle past it
    reset_quiet: assert property (@(posedge clk)
        reset |=> !dec_valid && !mem_req_valid)
        else $error("decode valid or refill request during or right after reset");

    // stalled decode sees the same entry, a redirect may withdraw it
    dec_hold: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !dec_ready && !(br_taken || flush || eret)
        |=> dec_valid && $stable(dec_pc) && $stable(dec_inst) && $stable(dec_bd)
            && $stable(dec_exc) && $stable(dec_exc_code))
        else $error("decode outputs changed while stalled");

    // refill request held until memory takes it
    mem_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("refill request dropped or address moved before acceptance");

    // address error entries carry no instruction
    adel_shape: assert property (@(posedge clk) disable iff (reset)
        dec_valid && dec_exc |-> dec_exc_code == `EXC_ADEL && dec_inst == '0)
        else $error("address error entry with wrong code or nonzero instruction");

    // hits only, so no refill
    no_refill: assert property (@(posedge clk) disable iff (reset)
        hit_loop |-> !mem_req_valid)
        else $error("refill request inside a loop of cached lines");

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // redirects, one cycle pulses
    input  logic      br_taken,
    input  addr_t     br_target,
    input  logic      br_delay_slot,
    input  logic      flush,
    input  logic      eret,
    input  addr_t     epc,
    // toward decode
    output logic      dec_valid,
    input  logic      dec_ready,
    output addr_t     dec_pc,
    output inst_t     dec_inst,
    output logic      dec_bd,
    output logic      dec_exc,
    output exc_code_t dec_exc_code,
    // line refill memory
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output addr_t     mem_req_addr,
    input  logic      mem_resp_valid,
    input  inst_t     mem_resp_data
);

    logic      req_valid;
    addr_t     req_addr;
    logic      addr_ok;
    logic      data_ok;
    inst_t     rdata;
    logic      rec_valid;     // side record per fetch
    addr_t     rec_pc;
    logic      rec_epoch;
    logic      rec_bd;
    logic      rec_exc;
    exc_code_t rec_exc_code;
    logic      epoch;         // current stream
    logic      slot_free;

    pc_gen u_pc_gen (
        .clk          (clk),
        .reset        (reset),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .br_delay_slot(br_delay_slot),
        .flush        (flush),
        .eret         (eret),
        .epc          (epc),
        .addr_ok      (addr_ok),
        .slot_free    (slot_free),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .rec_valid    (rec_valid),
        .rec_pc       (rec_pc),
        .rec_epoch    (rec_epoch),
        .rec_bd       (rec_bd),
        .rec_exc      (rec_exc),
        .rec_exc_code (rec_exc_code),
        .epoch        (epoch)
    );

    icache u_icache (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_data (mem_resp_data)
    );

    fetch_buffer u_fetch_buffer (
        .clk         (clk),
        .reset       (reset),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rec_valid   (rec_valid),
        .rec_pc      (rec_pc),
        .rec_epoch   (rec_epoch),
        .rec_bd      (rec_bd),
        .rec_exc     (rec_exc),
        .rec_exc_code(rec_exc_code),
        .epoch       (epoch),
        .dec_ready   (dec_ready),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .dec_bd      (dec_bd),
        .dec_exc     (dec_exc),
        .dec_exc_code(dec_exc_code),
        .slot_free   (slot_free)
    );

endmodule

`default_nettype wire

//--- fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_buffer import fetch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      data_ok,
    input  inst_t     rdata,
    input  logic      rec_valid,
    input  addr_t     rec_pc,
    input  logic      rec_epoch,
    input  logic      rec_bd,
    input  logic      rec_exc,
    input  exc_code_t rec_exc_code,
    input  logic      epoch,
    input  logic      dec_ready,
    output logic      dec_valid,
    output addr_t     dec_pc,
    output inst_t     dec_inst,
    output logic      dec_bd,
    output logic      dec_exc,
    output exc_code_t dec_exc_code,
    output logic      slot_free
);

    localparam int PTR_W = $clog2(`FB_DEPTH);

    // a slot is claimed at issue and filled by data_ok later
    logic [`FB_DEPTH-1:0] ent_valid;
    logic [`FB_DEPTH-1:0] ent_done;    // instruction present
    logic [`FB_DEPTH-1:0] ent_kill;    // redirect seen while queued
    logic [`FB_DEPTH-1:0] ent_epoch;
    logic [`FB_DEPTH-1:0] ent_bd;
    logic [`FB_DEPTH-1:0] ent_exc;
    addr_t                ent_pc   [`FB_DEPTH];
    inst_t                ent_inst [`FB_DEPTH];
    exc_code_t            ent_code [`FB_DEPTH];

    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     fill_ptr;    // oldest slot waiting on data

    logic                 epoch_q;
    logic                 epoch_flip;
    logic                 head_ready;
    logic                 head_stale;
    logic                 discard;
    logic                 pop;

    // address error records are done at push, so data skips them
    assign fill_ptr = ent_done[rd_ptr] ? rd_ptr + 1'b1 : rd_ptr;

    assign epoch_flip = (epoch != epoch_q);
    assign head_ready = ent_valid[rd_ptr] & ent_done[rd_ptr];
    assign head_stale = ent_kill[rd_ptr] | (ent_epoch[rd_ptr] != epoch);

    assign dec_valid = head_ready & ~head_stale;
    assign discard   = head_ready & head_stale;     // drop quietly
    assign pop       = (dec_valid & dec_ready) | discard;
    assign slot_free = pop;                         // credit back to pc_gen

    assign dec_pc       = ent_pc[rd_ptr];
    assign dec_inst     = ent_inst[rd_ptr];
    assign dec_bd       = ent_bd[rd_ptr];
    assign dec_exc      = ent_exc[rd_ptr];
    assign dec_exc_code = ent_code[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= '0;
            ent_done  <= '0;
            ent_kill  <= '0;
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            epoch_q   <= 1'b0;
        end else begin
            epoch_q <= epoch;
            if (epoch_flip) begin
                ent_kill <= ent_kill | ent_valid;   // sticky across repeat flips
            end
            if (data_ok) begin
                ent_done[fill_ptr] <= 1'b1;
            end
            if (pop) begin
                ent_valid[rd_ptr] <= 1'b0;
                rd_ptr            <= rd_ptr + 1'b1;
            end
            if (rec_valid) begin                    // credits keep a slot free
                ent_valid[wr_ptr] <= 1'b1;
                ent_done[wr_ptr]  <= rec_exc;
                ent_kill[wr_ptr]  <= 1'b0;
                wr_ptr            <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid) begin
            ent_pc[wr_ptr]    <= rec_pc;
            ent_epoch[wr_ptr] <= rec_epoch;
            ent_bd[wr_ptr]    <= rec_bd;
            ent_exc[wr_ptr]   <= rec_exc;
            ent_code[wr_ptr]  <= rec_exc_code;
            ent_inst[wr_ptr]  <= '0;                // stays zero on address error
        end
        if (data_ok) begin
            ent_inst[fill_ptr] <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module icache import fetch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    // fetch side, addr_ok / data_ok
    input  logic  req_valid,
    input  addr_t req_addr,
    output logic  addr_ok,
    output logic  data_ok,
    output inst_t rdata,
    // refill side
    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,
    input  logic  mem_resp_valid,
    input  inst_t mem_resp_data
);

    localparam int WORD_W    = $clog2(`IC_LINE_WORDS);
    localparam int LAST_BEAT = `IC_LINE_WORDS - 1;

    // storage, only the valid bits see reset
    logic [`IC_SETS-1:0] valid_bits;
    ic_tag_t             tag_arr  [`IC_SETS];
    inst_t               data_arr [`IC_SETS][`IC_LINE_WORDS];

    ic_state_t           state;
    logic [WORD_W-1:0]   beat_cnt;  // next refill beat

    // lookup stage, request accepted last cycle
    logic                s1_valid;
    addr_t               s1_addr;
    ic_tag_t             s1_tag;
    ic_index_t           s1_index;
    ic_offset_t          s1_offset;
    logic [WORD_W-1:0]   s1_word;

    logic                hit;
    logic                miss;
    logic                last_beat;

    assign {s1_tag, s1_index, s1_offset} = s1_addr;
    assign s1_word = s1_offset[WORD_W+1:2];   // drop byte bits

    assign hit  = valid_bits[s1_index] & (tag_arr[s1_index] == s1_tag);
    assign miss = s1_valid & ~hit;

    // no new request while a miss sits in s1 or a refill runs
    assign addr_ok = req_valid & (state == idle) & ~miss;

    // hits answer one cycle after acceptance, misses from done
    assign data_ok = ((state == idle) & s1_valid & hit) | (state == done);
    assign rdata   = data_arr[s1_index][s1_word];

    // line aligned refill request
    assign mem_req_valid = (state == refill_req);
    assign mem_req_addr  = {s1_tag, s1_index, ic_offset_t'(0)};

    assign last_beat = (beat_cnt == WORD_W'(LAST_BEAT));

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (addr_ok) begin
            s1_valid <= 1'b1;
        end else if (data_ok) begin
            s1_valid <= 1'b0;                 // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            s1_addr <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            beat_cnt   <= '0;
            valid_bits <= '0;
        end else begin
            case (state)
                idle: begin
                    if (miss) begin
                        state <= refill_req;
                    end
                end
                refill_req: begin
                    if (mem_req_ready) begin
                        state    <= refill_wait;
                        beat_cnt <= '0;
                    end
                end
                refill_wait: begin
                    if (mem_resp_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            valid_bits[s1_index] <= 1'b1;
                            state                <= done;
                        end
                    end
                end
                done: begin
                    state <= idle;            // missed word goes out now
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // beats arrive in word order
    always_ff @(posedge clk) begin
        if ((state == refill_wait) && mem_resp_valid) begin
            data_arr[s1_index][beat_cnt] <= mem_resp_data;
            if (last_beat) begin
                tag_arr[s1_index] <= s1_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module pc_gen import fetch_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      br_taken,
    input  addr_t     br_target,
    input  logic      br_delay_slot,
    input  logic      flush,
    input  logic      eret,
    input  addr_t     epc,
    input  logic      addr_ok,
    input  logic      slot_free,
    output logic      req_valid,
    output addr_t     req_addr,
    output logic      rec_valid,
    output addr_t     rec_pc,
    output logic      rec_epoch,
    output logic      rec_bd,
    output logic      rec_exc,
    output exc_code_t rec_exc_code,
    output logic      epoch
);

    addr_t       pc;           // next address to fetch
    logic        run_en;       // first cycle after reset stays quiet
    logic        halted;       // parked behind an address error
    logic        bd_next;      // next fetch sits in a delay slot
    logic [1:0]  credits;      // free buffer slots

    logic        redirect;
    addr_t       redirect_pc;
    logic        misaligned;
    logic        can_issue;
    logic        issued;       // accepted by the icache this cycle
    logic        exc_issue;    // address error record, bypasses the cache

    // eret beats flush beats branch
    assign redirect    = eret | flush | br_taken;
    assign redirect_pc = eret  ? epc :
                         flush ? `FETCH_EXC_VECTOR :
                                 br_target;

    assign misaligned = |pc[1:0];
    assign can_issue  = run_en & ~halted & (credits != 2'd0);

    assign req_valid = can_issue & ~misaligned;
    assign req_addr  = pc;
    assign issued    = req_valid & addr_ok;
    assign exc_issue = can_issue & misaligned;

    // side record, paired with data_ok in the buffer
    assign rec_valid    = issued | exc_issue;
    assign rec_pc       = pc;
    assign rec_epoch    = epoch;
    assign rec_bd       = bd_next;
    assign rec_exc      = exc_issue;
    assign rec_exc_code = exc_issue ? `EXC_ADEL : `EXC_NONE;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `FETCH_RESET_PC;
            epoch   <= 1'b0;
            run_en  <= 1'b0;
            halted  <= 1'b0;
            bd_next <= 1'b0;
            credits <= 2'(`FETCH_CREDITS);
        end else begin
            run_en <= 1'b1;

            // spend on issue, refund on slot release
            case ({rec_valid, slot_free})
                2'b10:   credits <= credits - 2'd1;
                2'b01:   credits <= credits + 2'd1;
                default: credits <= credits;    // both or neither
            endcase

            if (redirect) begin
                pc      <= redirect_pc;         // held until credits allow
                epoch   <= ~epoch;              // older stream goes stale
                halted  <= 1'b0;
                bd_next <= br_taken & br_delay_slot & ~eret & ~flush;
            end else if (exc_issue) begin
                halted <= 1'b1;                 // wait for a redirect
            end else if (issued) begin
                pc      <= pc + 32'd4;
                bd_next <= 1'b0;                // only the first one is the slot
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // cp0 style exception code
    typedef logic [4:0]  exc_code_t;

    // icache address split, {tag, index, offset}
    typedef logic [19:0] ic_tag_t;
    typedef logic [7:0]  ic_index_t;
    typedef logic [3:0]  ic_offset_t;   // byte within the line

    // icache controller states
    typedef enum logic [1:0] {
        idle,          // lookup, hits answered here
        refill_req,    // line request toward memory
        refill_wait,   // collecting beats
        done           // line written, return the missed word
    } ic_state_t;

endpackage

`default_nettype wire

//--- fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// boot rom entry, first fetch out of reset
`define FETCH_RESET_PC   32'hbfc00000

// general exception entry
`define FETCH_EXC_VECTOR 32'hbfc00380

// icache geometry, direct mapped
`define IC_SETS          256
`define IC_LINE_WORDS    4      // 16 byte lines

// fetch buffer depth, also the number of fetch credits
`define FB_DEPTH         2
`define FETCH_CREDITS    2

// exception codes as seen by decode
`define EXC_ADEL         5'd4         // address error on fetch
`define EXC_NONE         5'b11111     // no exception

`endif
